// File: Bender.yml
package:
  name: sprite_engine

sources:
  - files:
      - hdl/sprite_pkg.sv
      - hdl/pixel_if.sv
      - hdl/sync_ram.sv
      - hdl/sprite_scanner.sv
      - hdl/line_buffer.sv
      - hdl/collision_detector.sv
      - hdl/sprite_engine.sv
  - target: test
    files:
      - test/sprite_mem_model.sv
      - test/tb_sprite_engine.sv

// File: hdl/collision_detector.sv
`timescale 1ns/1ps

module collision_detector #(
	parameter int SPRITE_COUNT = 32,
	parameter int LINE_WIDTH = 352
) (
	input  logic                    clk,
	input  logic                    rst_n,
	pixel_if.listener               pix,
	input  logic                    collision_clear,
	output logic [SPRITE_COUNT-1:0] collision_flags
);
	import sprite_pkg::*;

	typedef logic [SPRITE_COUNT-1:0] mask_t;

	col_state_t state;
	logic       sel;
	// Mark side
	logic       mark_req;
	logic       mark_pend;
	lb_addr_t   mark_col;
	lb_addr_t   mark_addr;
	mask_t      mark_bit;
	mask_t      mark_rdata;
	// Scan side
	lb_addr_t   scan_addr;
	logic       scan_valid;
	mask_t      scan_rdata;
	mask_t      acc;
	mask_t      acc_next;
	mask_t      rd_data [2];

	// Marks landing outside the visible line are ignored
	assign mark_col = pix.pixel_x - lb_addr_t'(SPRITE_SIZE);
	assign mark_req = pix.pixel_valid && pix.pixel_collide &&
		(pix.pixel_x >= lb_addr_t'(SPRITE_SIZE)) && (mark_col < lb_addr_t'(LINE_WIDTH));

	always_ff @(posedge clk)
	begin
		if (mark_req)
		begin
			mark_addr <= mark_col;
			mark_bit <= mask_t'(1) << pix.pixel_sprite;
		end
	end

	assign mark_rdata = rd_data[sel];
	assign scan_rdata = rd_data[~sel];

	// Read-modify-write on the mark side and read-and-zero on the scan side
	for (genvar g = 0; g < 2; g++)
	begin : g_buf
		logic is_mark;

		assign is_mark = (sel == 1'(g));

		sync_ram #(
			.ADDR_WIDTH($bits(lb_addr_t)),
			.DATA_WIDTH(SPRITE_COUNT)
		) i_ram (
			.clk   (clk),
			.addr  (is_mark ? (mark_pend ? mark_addr : mark_col) : scan_addr),
			.wr    (is_mark ? mark_pend : (state == COL_SCAN)),
			.wdata (is_mark ? (mark_rdata | mark_bit) : mask_t'('0)),
			.rdata (rd_data[g])
		);
	end

	// Only columns shared by two or more sprites count
	always_comb
	begin
		acc_next = acc;
		if (scan_valid && bit_count(MASK_MAX'(scan_rdata)) >= 2)
		begin
			acc_next = acc | scan_rdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= COL_IDLE;
			sel <= 1'b0;
			mark_pend <= 1'b0;
			scan_valid <= 1'b0;
			collision_flags <= '0;
		end
		else
		begin
			mark_pend <= mark_req;
			scan_valid <= (state == COL_SCAN);
			acc <= acc_next;

			unique case (state)
				COL_IDLE:
				begin
					if (pix.line_start)
					begin
						sel <= ~sel;
						scan_addr <= '0;
						acc <= '0;
						state <= COL_SCAN;
					end
				end
				COL_SCAN:
				begin
					if (scan_addr == lb_addr_t'(LINE_WIDTH - 1))
					begin
						state <= COL_DONE;
					end
					scan_addr <= scan_addr + 1'b1;
				end
				// Last column's data lands here
				COL_DONE:
				begin
					state <= COL_IDLE;
				end
				default:
				begin
					state <= COL_IDLE;
				end
			endcase

			if (collision_clear)
			begin
				collision_flags <= '0;
			end
			else if (state == COL_DONE)
			begin
				collision_flags <= collision_flags | acc_next;
			end
		end
	end

	a_mark_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		mark_req |=> !mark_req);

	// Scan of the previous line finishes before the next swap
	a_scan_done: assert property (@(posedge clk) disable iff (!rst_n)
		pix.line_start |-> state == COL_IDLE);

endmodule

// File: hdl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
	parameter int LINE_WIDTH = 352
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sprite_pkg::lb_addr_t hcnt,
	pixel_if.listener            pix,
	output logic [7:0]           spr_r,
	output logic [7:0]           spr_g,
	output logic [7:0]           spr_b,
	output logic                 spr_a
);
	import sprite_pkg::*;

	// Clear covers the visible line plus the left margin
	localparam int CLEAR_LEN = LINE_WIDTH + SPRITE_SIZE;

	logic     sel;
	logic     clearing;
	lb_addr_t clr_addr;
	lb_addr_t wr_addr;
	lb_addr_t rd_addr;
	logic     wr_en;
	colour_t  wr_data;
	colour_t  rd_data [2];
	colour_t  disp;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sel <= 1'b0;
			clearing <= 1'b0;
		end
		else if (pix.line_start)
		begin
			sel <= ~sel;
			clearing <= 1'b1;
			clr_addr <= '0;
		end
		else if (clearing)
		begin
			if (clr_addr == lb_addr_t'(CLEAR_LEN - 1))
			begin
				clearing <= 1'b0;
			end
			clr_addr <= clr_addr + 1'b1;
		end
	end

	assign wr_addr = clearing ? clr_addr : pix.pixel_x;
	assign wr_en = clearing || pix.pixel_valid;
	assign wr_data = clearing ? colour_t'('0) : pix.pixel_colour;
	assign rd_addr = hcnt + lb_addr_t'(SPRITE_SIZE);

	// sel picks the half being drawn while the other half is on screen
	for (genvar g = 0; g < 2; g++)
	begin : g_half
		logic is_wr;

		assign is_wr = (sel == 1'(g));

		sync_ram #(
			.ADDR_WIDTH($bits(lb_addr_t)),
			.DATA_WIDTH($bits(colour_t))
		) i_ram (
			.clk   (clk),
			.addr  (is_wr ? wr_addr : rd_addr),
			.wr    (is_wr && wr_en),
			.wdata (wr_data),
			.rdata (rd_data[g])
		);
	end

	assign disp = rd_data[~sel];

	// Top bits repeated to fill out 8 bits
	assign spr_r = {disp.r, disp.r[4:2]};
	assign spr_g = {disp.g, disp.g[4:2]};
	assign spr_b = {disp.b, disp.b[4:2]};
	assign spr_a = disp.a;

	a_no_draw_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
		clearing |-> !pix.pixel_valid);

endmodule

// File: hdl/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if #(
	parameter int SPRITE_COUNT = 32
);
	import sprite_pkg::*;

	logic                            pixel_valid;
	lb_addr_t                        pixel_x;
	colour_t                         pixel_colour;
	logic [$clog2(SPRITE_COUNT)-1:0] pixel_sprite;
	logic                            pixel_collide;
	// Swap event for every buffer behind the scanner
	logic                            line_start;

	modport master (
		output pixel_valid,
		output pixel_x,
		output pixel_colour,
		output pixel_sprite,
		output pixel_collide,
		output line_start
	);

	modport listener (
		input  pixel_valid,
		input  pixel_x,
		input  pixel_colour,
		input  pixel_sprite,
		input  pixel_collide,
		input  line_start
	);

endinterface

// File: hdl/sprite_engine.sv
`timescale 1ns/1ps

module sprite_engine #(
	parameter int SPRITE_COUNT = 32,
	parameter int LINE_WIDTH = 352
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hsync,
	input  logic                    vblank,
	input  logic [8:0]              hcnt,
	input  logic [8:0]              vcnt,
	output logic [$clog2(SPRITE_COUNT * sprite_pkg::ENTRY_BYTES)-1:0] spriteram_addr,
	input  logic [7:0]              spriteram_data,
	output logic [13:0]             spriterom_addr,
	input  logic [7:0]              spriterom_data,
	output logic [7:0]              palrom_addr,
	input  sprite_pkg::colour_t     palrom_data,
	input  logic                    collision_clear,
	output logic [SPRITE_COUNT-1:0] collision_flags,
	output logic [7:0]              spr_r,
	output logic [7:0]              spr_g,
	output logic [7:0]              spr_b,
	output logic                    spr_a
);
	import sprite_pkg::*;

	pixel_if #(.SPRITE_COUNT(SPRITE_COUNT)) pix_bus ();

	// Scanner waits out the line memory clear
	sprite_scanner #(
		.SPRITE_COUNT (SPRITE_COUNT),
		.CLEAR_CYCLES (LINE_WIDTH + SPRITE_SIZE)
	) i_scanner (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.vblank         (vblank),
		.vcnt           (vcnt),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.spriterom_addr (spriterom_addr),
		.spriterom_data (spriterom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data),
		.pix            (pix_bus.master)
	);

	line_buffer #(
		.LINE_WIDTH (LINE_WIDTH)
	) i_line_buffer (
		.clk   (clk),
		.rst_n (rst_n),
		.hcnt  (hcnt),
		.pix   (pix_bus.listener),
		.spr_r (spr_r),
		.spr_g (spr_g),
		.spr_b (spr_b),
		.spr_a (spr_a)
	);

	collision_detector #(
		.SPRITE_COUNT (SPRITE_COUNT),
		.LINE_WIDTH   (LINE_WIDTH)
	) i_collision (
		.clk             (clk),
		.rst_n           (rst_n),
		.pix             (pix_bus.listener),
		.collision_clear (collision_clear),
		.collision_flags (collision_flags)
	);

endmodule

// File: hdl/sprite_pkg.sv
package sprite_pkg;

	// Sprites are square, and column 0 sits this far into the line memory
	parameter int SPRITE_SIZE = 16;
	parameter int ENTRY_BYTES = 4;

	// Widest sprite mask the population count handles
	parameter int MASK_MAX = 64;

	// Palette colour with red in the low bits and alpha on top
	typedef struct packed {
		logic       a;
		logic [4:0] b;
		logic [4:0] g;
		logic [4:0] r;
	} colour_t;

	typedef logic [8:0] lb_addr_t;

	typedef enum logic [3:0] {
		SCAN_IDLE,
		SCAN_CLEAR,
		SCAN_READ_Y_HI,
		SCAN_READ_Y_LO,
		SCAN_CHECK_Y,
		SCAN_READ_X_HI,
		SCAN_READ_X_LO,
		SCAN_SETUP,
		SCAN_FETCH,
		SCAN_STAGE,
		SCAN_WRITE,
		SCAN_DONE
	} scan_state_t;

	typedef enum logic [1:0] {
		COL_IDLE,
		COL_SCAN,
		COL_DONE
	} col_state_t;

	function automatic int unsigned bit_count(input logic [MASK_MAX-1:0] mask);
		int unsigned n;
		n = 0;
		for (int i = 0; i < MASK_MAX; i++)
		begin
			n += mask[i];
		end
		return n;
	endfunction

endpackage

// File: hdl/sprite_scanner.sv
`timescale 1ns/1ps

module sprite_scanner #(
	parameter int SPRITE_COUNT = 32,
	parameter int CLEAR_CYCLES = 368
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hsync,
	input  logic                   vblank,
	input  logic [8:0]             vcnt,
	output logic [$clog2(SPRITE_COUNT * sprite_pkg::ENTRY_BYTES)-1:0] spriteram_addr,
	input  logic [7:0]             spriteram_data,
	output logic [13:0]            spriterom_addr,
	input  logic [7:0]             spriterom_data,
	output logic [7:0]             palrom_addr,
	input  sprite_pkg::colour_t    palrom_data,
	pixel_if.master                pix
);
	import sprite_pkg::*;

	localparam int IDX_W = $clog2(SPRITE_COUNT);
	localparam int RAM_AW = $clog2(SPRITE_COUNT * ENTRY_BYTES);
	localparam int CLR_W = $clog2(CLEAR_CYCLES);

	scan_state_t       state;
	logic              hsync_q;
	logic              hold;
	logic [CLR_W-1:0]  clr_cnt;
	logic [IDX_W-1:0]  spr_idx;
	logic              last_sprite;
	logic [RAM_AW-1:0] next_entry;
	logic [9:0]        active_y;
	logic [9:0]        spr_y;
	lb_addr_t          spr_x;
	logic              spr_en;
	logic              spr_collide;
	logic [1:0]        spr_pal;
	logic [5:0]        spr_image;
	logic [3:0]        row_off;
	logic [3:0]        pix_idx;
	logic              y_hit;

	assign last_sprite = (spr_idx == IDX_W'(SPRITE_COUNT - 1));
	assign next_entry = RAM_AW'((int'(spr_idx) + 1) * ENTRY_BYTES);

	// Row is offset by the sprite height so the compare never goes negative
	assign y_hit = spr_en && ({1'b0, active_y} >= {1'b0, spr_y}) &&
		({1'b0, active_y} < {1'b0, spr_y} + 11'(SPRITE_SIZE));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= SCAN_IDLE;
			hsync_q <= 1'b0;
			hold <= 1'b0;
			pix.line_start <= 1'b0;
			pix.pixel_valid <= 1'b0;
		end
		else
		begin
			hsync_q <= hsync;
			pix.line_start <= 1'b0;
			pix.pixel_valid <= 1'b0;

			// One idle cycle after each new memory address
			if (hold)
			begin
				hold <= 1'b0;
			end
			else
			begin
				unique case (state)
					SCAN_IDLE:
					begin
						if (hsync && !hsync_q)
						begin
							pix.line_start <= 1'b1;
							active_y <= 10'(vcnt) + 10'(SPRITE_SIZE + 1);
							clr_cnt <= '0;
							state <= SCAN_CLEAR;
						end
					end

					// Line memory clears its write half meanwhile
					SCAN_CLEAR:
					begin
						if (clr_cnt == CLR_W'(CLEAR_CYCLES - 1))
						begin
							spr_idx <= '0;
							spriteram_addr <= '0;
							hold <= 1'b1;
							state <= SCAN_READ_Y_HI;
						end
						else
						begin
							clr_cnt <= clr_cnt + 1'b1;
						end
					end

					SCAN_READ_Y_HI:
					begin
						spr_en <= spriteram_data[7];
						spr_collide <= spriteram_data[6];
						spr_pal <= spriteram_data[5:4];
						spr_y[9:8] <= spriteram_data[1:0];
						spriteram_addr <= spriteram_addr + 1'b1;
						hold <= 1'b1;
						state <= SCAN_READ_Y_LO;
					end

					SCAN_READ_Y_LO:
					begin
						spr_y[7:0] <= spriteram_data;
						spriteram_addr <= spriteram_addr + 1'b1;
						state <= SCAN_CHECK_Y;
					end

					SCAN_CHECK_Y:
					begin
						if (y_hit)
						begin
							row_off <= 4'(active_y - spr_y);
							state <= SCAN_READ_X_HI;
						end
						else if (last_sprite)
						begin
							state <= SCAN_DONE;
						end
						else
						begin
							spr_idx <= spr_idx + 1'b1;
							spriteram_addr <= next_entry;
							hold <= 1'b1;
							state <= SCAN_READ_Y_HI;
						end
					end

					// Byte 2 address went out two cycles ago
					SCAN_READ_X_HI:
					begin
						spr_image <= spriteram_data[7:2];
						spr_x[8] <= spriteram_data[0];
						spriteram_addr <= spriteram_addr + 1'b1;
						hold <= 1'b1;
						state <= SCAN_READ_X_LO;
					end

					SCAN_READ_X_LO:
					begin
						spr_x[7:0] <= spriteram_data;
						state <= SCAN_SETUP;
					end

					SCAN_SETUP:
					begin
						spriterom_addr <= {spr_image, row_off, 4'b0000};
						pix_idx <= '0;
						hold <= 1'b1;
						state <= SCAN_FETCH;
					end

					SCAN_FETCH:
					begin
						palrom_addr <= {spr_pal, spriterom_data[4:0], 1'b0};
						spriterom_addr <= spriterom_addr + 1'b1;
						hold <= 1'b1;
						state <= SCAN_STAGE;
					end

					// Transparent pixels pass through write without a strobe
					SCAN_STAGE:
					begin
						pix.pixel_valid <= palrom_data.a;
						pix.pixel_x <= spr_x + lb_addr_t'(pix_idx);
						pix.pixel_colour <= palrom_data;
						pix.pixel_sprite <= spr_idx;
						pix.pixel_collide <= spr_collide && !vblank;
						state <= SCAN_WRITE;
					end

					SCAN_WRITE:
					begin
						if (pix_idx != 4'(SPRITE_SIZE - 1))
						begin
							pix_idx <= pix_idx + 1'b1;
							state <= SCAN_FETCH;
						end
						else if (last_sprite)
						begin
							state <= SCAN_DONE;
						end
						else
						begin
							spr_idx <= spr_idx + 1'b1;
							spriteram_addr <= next_entry;
							hold <= 1'b1;
							state <= SCAN_READ_Y_HI;
						end
					end

					SCAN_DONE:
					begin
						state <= SCAN_IDLE;
					end

					default:
					begin
						state <= SCAN_IDLE;
					end
				endcase
			end
		end
	end

	// Both consumers rely on pixels never arriving back to back
	a_pixel_in_write: assert property (@(posedge clk) disable iff (!rst_n)
		pix.pixel_valid |-> (state == SCAN_WRITE) ##1 !pix.pixel_valid);

endmodule

// File: hdl/sync_ram.sv
`timescale 1ns/1ps

module sync_ram #(
	parameter int ADDR_WIDTH = 9,
	parameter int DATA_WIDTH = 16
) (
	input  logic                  clk,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic                  wr,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// Read returns the old word when the same address is written
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// File: sprite_engine.f
hdl/sprite_pkg.sv
hdl/pixel_if.sv
hdl/sync_ram.sv
hdl/sprite_scanner.sv
hdl/line_buffer.sv
hdl/collision_detector.sv
hdl/sprite_engine.sv
test/sprite_mem_model.sv
test/tb_sprite_engine.sv

// File: test/sprite_mem_model.sv
`timescale 1ns/1ps

module sprite_mem_model (
	input  logic                clk,
	input  logic [6:0]          spriteram_addr,
	output logic [7:0]          spriteram_data,
	input  logic [13:0]         spriterom_addr,
	output logic [7:0]          spriterom_data,
	input  logic [7:0]          palrom_addr,
	output sprite_pkg::colour_t palrom_data
);
	import sprite_pkg::*;

	// Contents are loaded by the testbench through hierarchical access
	logic [7:0] sprite_ram [128];
	logic [7:0] image_rom [16384];
	colour_t    palette [256];

	// All three memories answer one cycle after the address is seen
	always_ff @(posedge clk)
	begin
		spriteram_data <= sprite_ram[spriteram_addr];
		spriterom_data <= image_rom[spriterom_addr];
		palrom_data <= palette[palrom_addr];
	end

endmodule

// File: test/tb_sprite_engine.sv
`timescale 1ns/1ps

module tb_sprite_engine;
	import sprite_pkg::*;

	localparam int N_SCENES = 8;
	localparam int LINE_CLKS = 1024;

	logic        clk;
	logic        rst_n;
	logic        hsync;
	logic        vblank;
	logic [8:0]  hcnt;
	logic [8:0]  vcnt;
	logic [6:0]  spriteram_addr;
	logic [7:0]  spriteram_data;
	logic [13:0] spriterom_addr;
	logic [7:0]  spriterom_data;
	logic [7:0]  palrom_addr;
	colour_t     palrom_data;
	logic        collision_clear;
	logic [31:0] collision_flags;
	logic [7:0]  spr_r;
	logic [7:0]  spr_g;
	logic [7:0]  spr_b;
	logic        spr_a;

	int          tcnt;
	int          seed;
	int          errors;
	int          checks;

	// Scene table with up to three sprites per scene in ascending index order
	int          scene_row [N_SCENES];
	logic        scene_vb [N_SCENES];
	logic [31:0] scene_flags [N_SCENES];
	int          scene_idx [N_SCENES][3];
	logic [31:0] scene_entry [N_SCENES][3];
	int          scene_cols [N_SCENES][4];

	sprite_engine i_sprite_engine (
		.clk             (clk),
		.rst_n           (rst_n),
		.hsync           (hsync),
		.vblank          (vblank),
		.hcnt            (hcnt),
		.vcnt            (vcnt),
		.spriteram_addr  (spriteram_addr),
		.spriteram_data  (spriteram_data),
		.spriterom_addr  (spriterom_addr),
		.spriterom_data  (spriterom_data),
		.palrom_addr     (palrom_addr),
		.palrom_data     (palrom_data),
		.collision_clear (collision_clear),
		.collision_flags (collision_flags),
		.spr_r           (spr_r),
		.spr_g           (spr_g),
		.spr_b           (spr_b),
		.spr_a           (spr_a)
	);

	sprite_mem_model i_mem (
		.clk            (clk),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.spriterom_addr (spriterom_addr),
		.spriterom_data (spriterom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#20 clk = ~clk;
		end
	end

	// Video timing with the hsync pulse from column 400
	initial
	begin
		tcnt = 0;
		hcnt = '0;
		hsync = 1'b0;
		forever
		begin
			@(negedge clk);
			tcnt = (tcnt + 1) % LINE_CLKS;
			hcnt = tcnt[8:0];
			hsync = (tcnt >= 400) && (tcnt < 432);
		end
	end

	initial
	begin
		#((N_SCENES * 4 + 4) * LINE_CLKS * 40);
		$display("Timeout: the scene sequence did not complete");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] make_entry(input logic en, input logic coll,
		input logic [1:0] pal, input int y, input int img, input int x);
		logic [9:0] yv;
		logic [8:0] xv;
		yv = y[9:0];
		xv = x[8:0];
		return {en, coll, pal, 2'b00, yv[9:8], yv[7:0], img[5:0], 1'b0, xv[8], xv[7:0]};
	endfunction

	task automatic set_sprite(input int s, input int slot, input int idx, input logic en,
		input logic coll, input logic [1:0] pal, input int y, input int img, input int x);
		scene_idx[s][slot] = idx;
		scene_entry[s][slot] = make_entry(en, coll, pal, y, img, x);
	endtask

	task automatic set_scene(input int s, input int row, input logic vb,
		input logic [31:0] flags, input int c0, input int c1, input int c2, input int c3);
		scene_row[s] = row;
		scene_vb[s] = vb;
		scene_flags[s] = flags;
		scene_cols[s][0] = c0;
		scene_cols[s][1] = c1;
		scene_cols[s][2] = c2;
		scene_cols[s][3] = c3;
	endtask

	// Expected colour at a screen column from the sprite format rules
	function automatic colour_t predict_colour(input int s, input int col);
		colour_t    res;
		colour_t    c;
		logic [7:0] b0;
		logic [7:0] rom_byte;
		int         y;
		int         x;
		int         roff;
		int         row;
		res = '0;
		row = scene_row[s];
		for (int k = 0; k < 3; k++)
		begin
			b0 = scene_entry[s][k][31:24];
			if (scene_idx[s][k] >= 0 && b0[7])
			begin
				y = {b0[1:0], scene_entry[s][k][23:16]};
				x = {scene_entry[s][k][9:8], scene_entry[s][k][7:0]};
				if (row >= y - 16 && row <= y - 1)
				begin
					roff = row - y + 16;
					for (int i = 0; i < 16; i++)
					begin
						if (x + i - 16 == col)
						begin
							rom_byte = i_mem.image_rom[scene_entry[s][k][15:10] * 256 +
								roff * 16 + i];
							c = i_mem.palette[{b0[5:4], rom_byte[4:0], 1'b0}];
							if (c.a)
							begin
								res = c;
							end
						end
					end
				end
			end
		end
		return res;
	endfunction

	// Scale a 5-bit channel to 8 bits, top bits refill the low end
	function automatic logic [7:0] expand_channel(input logic [4:0] v);
		return 8'(int'(v) * 8 + int'(v) / 4);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	// Returns on the falling edge after the clock that saw tcnt == n
	task automatic wait_tcnt(input int n);
		do
		begin
			@(posedge clk);
		end
		while (tcnt != n);
		@(negedge clk);
	endtask

	task automatic pulse_clear();
		collision_clear = 1'b1;
		@(negedge clk);
		collision_clear = 1'b0;
	endtask

	task automatic load_table(input int s);
		for (int a = 0; a < 128; a++)
		begin
			i_mem.sprite_ram[a] = 8'h00;
		end
		for (int k = 0; k < 3; k++)
		begin
			if (scene_idx[s][k] >= 0)
			begin
				for (int b = 0; b < 4; b++)
				begin
					i_mem.sprite_ram[scene_idx[s][k] * 4 + b] =
						scene_entry[s][k][31 - 8 * b -: 8];
				end
			end
		end
	endtask

	task automatic check_column(input int s, input int col);
		colour_t exp;
		exp = predict_colour(s, col);
		wait_tcnt(col);
		check_value("spr_r", expand_channel(exp.r), spr_r);
		check_value("spr_g", expand_channel(exp.g), spr_g);
		check_value("spr_b", expand_channel(exp.b), spr_b);
		check_value("spr_a", exp.a, spr_a);
	endtask

	task automatic run_scene(input int s);
		// New table goes out at this line's hsync
		wait_tcnt(200);
		load_table(s);
		vcnt = 9'(scene_row[s] - 1);
		vblank = scene_vb[s];
		// Drop flags left by the previous scene
		wait_tcnt(200);
		pulse_clear();
		wait_tcnt(200);
		// By the fourth line display and flags both reflect this scene
		wait_tcnt(0);
		check_value("collision_flags", scene_flags[s], collision_flags);
		for (int c = 0; c < 4; c++)
		begin
			check_column(s, scene_cols[s][c]);
		end
		if (scene_flags[s] != 0)
		begin
			wait_tcnt(360);
			pulse_clear();
			@(negedge clk);
			check_value("collision_flags", 32'h0, collision_flags);
		end
	endtask

	initial
	begin
		logic [31:0] r;
		rst_n = 1'b0;
		vcnt = '0;
		vblank = 1'b0;
		collision_clear = 1'b0;
		errors = 0;
		checks = 0;
		seed = 46507;

		for (int a = 0; a < 16384; a++)
		begin
			r = $random(seed);
			i_mem.image_rom[a] = r[7:0];
		end
		// Palette 0 is fully opaque and palette 3 fully transparent
		for (int a = 0; a < 256; a++)
		begin
			r = $random(seed);
			i_mem.palette[a] = r[15:0];
			if (a < 64)
			begin
				i_mem.palette[a].a = 1'b1;
			end
			else if (a >= 192)
			begin
				i_mem.palette[a].a = 1'b0;
			end
		end
		for (int a = 0; a < 128; a++)
		begin
			i_mem.sprite_ram[a] = 8'h00;
		end

		for (int s = 0; s < N_SCENES; s++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				scene_idx[s][k] = -1;
				scene_entry[s][k] = '0;
			end
		end
		set_scene(0, 50, 1'b0, 32'h0, 1, 16, 100, 200);
		set_sprite(1, 0, 3, 1'b1, 1'b0, 2'd0, 100, 5, 40);
		set_scene(1, 90, 1'b0, 32'h0, 23, 24, 39, 40);
		set_sprite(2, 0, 5, 1'b1, 1'b0, 2'd0, 60, 9, 100);
		set_sprite(2, 1, 7, 1'b1, 1'b0, 2'd3, 58, 12, 108);
		set_scene(2, 50, 1'b0, 32'h0, 85, 91, 95, 107);
		set_sprite(3, 0, 2, 1'b0, 1'b0, 2'd0, 116, 1, 60);
		set_sprite(3, 1, 4, 1'b1, 1'b0, 2'd0, 100, 2, 150);
		set_sprite(3, 2, 6, 1'b1, 1'b0, 2'd2, 116, 20, 250);
		set_scene(3, 100, 1'b0, 32'h0, 45, 140, 234, 249);
		set_sprite(4, 0, 1, 1'b1, 1'b1, 2'd0, 150, 3, 200);
		set_sprite(4, 1, 9, 1'b1, 1'b1, 2'd0, 145, 7, 208);
		set_scene(4, 140, 1'b0, 32'h0000_0202, 184, 195, 200, 215);
		set_sprite(5, 0, 1, 1'b1, 1'b1, 2'd0, 150, 3, 200);
		set_sprite(5, 1, 9, 1'b1, 1'b0, 2'd0, 145, 7, 208);
		set_scene(5, 140, 1'b0, 32'h0, 184, 195, 200, 215);
		set_sprite(6, 0, 1, 1'b1, 1'b1, 2'd0, 220, 3, 200);
		set_sprite(6, 1, 9, 1'b1, 1'b1, 2'd0, 215, 7, 208);
		set_scene(6, 210, 1'b1, 32'h0, 184, 195, 200, 215);
		set_sprite(7, 0, 1, 1'b1, 1'b1, 2'd0, 150, 3, 200);
		set_scene(7, 140, 1'b0, 32'h0, 184, 190, 199, 205);

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("collision_flags", 32'h0, collision_flags);

		for (int s = 0; s < N_SCENES; s++)
		begin
			run_scene(s);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
